// ==== all.f ====
aes_stream_pkg.sv
block_ram.sv
axis_block_packer.sv
block_xor_engine.sv
axis_block_sender.sv
aes_stream_top.sv
aes_stream_properties.sv
tb_aes_stream.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_aes_stream \
        -Mdir obj_dir -f all.f -o sim_tb \
        && ./obj_dir/sim_tb > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^>>> PASS$" sim.log && exit 0 || exit 1

// ==== tb_aes_stream.sv ====
`default_nettype none

module tb_aes_stream;

        timeunit 1ns;
        timeprecision 100ps;

        import aes_stream_pkg::*;

        localparam int wait_limit  = 2000;
        localparam int drain_limit = 6000;

        logic  s00_axis_aclk;
        logic  rst_n;
        word_t s00_axis_tdata;
        logic  s00_axis_tvalid;
        logic  s00_axis_tlast;
        logic  s00_axis_tready;
        word_t m00_axis_tdata;
        logic  m00_axis_tvalid;
        logic  m00_axis_tlast;
        logic  m00_axis_tready;

        // Expected output words and their tlast flags
        word_t exp_data [$];
        logic  exp_last [$];

        int errors;
        int tests_run;
        int tests_failed;
        int words_pushed;
        int words_seen;
        int stall_pct;

        aes_stream_top aes_stream_top_inst (
                .s00_axis_aclk   (s00_axis_aclk),
                .rst_n           (rst_n),
                .s00_axis_tdata  (s00_axis_tdata),
                .s00_axis_tvalid (s00_axis_tvalid),
                .s00_axis_tlast  (s00_axis_tlast),
                .s00_axis_tready (s00_axis_tready),
                .m00_axis_tdata  (m00_axis_tdata),
                .m00_axis_tvalid (m00_axis_tvalid),
                .m00_axis_tlast  (m00_axis_tlast),
                .m00_axis_tready (m00_axis_tready)
        );

        initial begin
                s00_axis_aclk = 1'b0;
                forever #10 s00_axis_aclk = ~s00_axis_aclk;
        end

        task automatic stop_on_timeout(input string msg);
                $display("timeout at %0t: %s", $time, msg);
                $display(">>> FAIL");
                $finish;
        endtask

        // Starts and ends on a falling edge
        task automatic send_word(input word_t w, input logic last, input int gap_pct);
                int n;
                n = 0;
                while (n < 8 && $urandom_range(99) < gap_pct) begin
                        @(negedge s00_axis_aclk);
                        n++;
                end
                s00_axis_tdata  = w;
                s00_axis_tlast  = last;
                s00_axis_tvalid = 1'b1;
                n = 0;
                while (!s00_axis_tready) begin
                        @(negedge s00_axis_aclk);
                        n++;
                        if (n > wait_limit) begin
                                stop_on_timeout("input word was never accepted");
                        end
                end
                @(negedge s00_axis_aclk);
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast  = 1'b0;
        endtask

        task automatic send_frame(input int nblk, input logic use_tlast, input int gap_pct);
                word_t cmd;
                word_t w;
                logic  last;
                cmd = $urandom;
                send_word(cmd, 1'b0, gap_pct);
                // Previous frame has to be fully sent before a new command is taken
                assert (exp_data.size() == 0) else begin
                        $display("error at %0t: command taken with %0d output words pending",
                                 $time, exp_data.size());
                        errors++;
                end
                for (int i = 0; i < nblk * words_per_block; i++) begin
                        w    = $urandom;
                        last = (i == nblk * words_per_block - 1);
                        exp_data.push_back(w ^ cmd);
                        exp_last.push_back(last);
                        words_pushed++;
                        send_word(w, use_tlast && last, gap_pct);
                end
        endtask

        task automatic wait_for_drain();
                int n;
                n = 0;
                while (exp_data.size() != 0 || m00_axis_tvalid) begin
                        @(negedge s00_axis_aclk);
                        n++;
                        if (n > drain_limit) begin
                                stop_on_timeout("output words still missing after frame");
                        end
                end
                repeat (3) @(negedge s00_axis_aclk);
        endtask

        task automatic finish_test(input string name, input int err_before);
                assert (words_seen == words_pushed) else begin
                        $display("error at %0t: %s got %0d words, expected %0d",
                                 $time, name, words_seen, words_pushed);
                        errors++;
                end
                tests_run++;
                if (errors != err_before) begin
                        tests_failed++;
                        $display("test %0d %s: failed", tests_run, name);
                end else begin
                        $display("test %0d %s: ok", tests_run, name);
                end
                words_pushed = 0;
                words_seen   = 0;
        endtask

        // ==================================================
        // Random output ready and model compare
        // ==================================================
        initial begin
                word_t w;
                logic  l;
                forever begin
                        @(negedge s00_axis_aclk);
                        if (rst_n) begin
                                m00_axis_tready = ($urandom_range(99) >= stall_pct);
                                if (m00_axis_tvalid) begin
                                        assert (!s00_axis_tready) else begin
                                                $display("error at %0t: input ready while output pending",
                                                         $time);
                                                errors++;
                                        end
                                end
                                if (m00_axis_tvalid && m00_axis_tready) begin
                                        words_seen++;
                                        assert (exp_data.size() > 0) else begin
                                                $display("error at %0t: unexpected output word %h",
                                                         $time, m00_axis_tdata);
                                                errors++;
                                        end
                                        if (exp_data.size() > 0) begin
                                                w = exp_data.pop_front();
                                                l = exp_last.pop_front();
                                                assert (m00_axis_tdata == w) else begin
                                                        $display("error at %0t: data %h, expected %h",
                                                                 $time, m00_axis_tdata, w);
                                                        errors++;
                                                end
                                                assert (m00_axis_tlast == l) else begin
                                                        $display("error at %0t: tlast %b, expected %b",
                                                                 $time, m00_axis_tlast, l);
                                                        errors++;
                                                end
                                        end
                                end
                        end
                end
        end

        // ==================================================
        // Test sequence
        // ==================================================
        initial begin
                int e;
                s00_axis_tdata  = '0;
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast  = 1'b0;
                m00_axis_tready = 1'b0;
                rst_n           = 1'b0;
                errors = 0;
                tests_run = 0;
                tests_failed = 0;
                words_pushed = 0;
                words_seen = 0;
                stall_pct = 0;
                void'($urandom(32'h7b29_6645));
                repeat (2) @(posedge s00_axis_aclk);
                @(negedge s00_axis_aclk);
                rst_n = 1'b1;
                @(negedge s00_axis_aclk);

                e = errors;
                assert (!m00_axis_tvalid && !s00_axis_tready) else begin
                        $display("error at %0t: stream outputs not idle after reset", $time);
                        errors++;
                end
                finish_test("reset state", e);

                e = errors;
                send_frame(1, 1'b1, 0);
                wait_for_drain();
                finish_test("single block", e);

                e = errors;
                for (int f = 0; f < 5; f++) begin
                        send_frame($urandom_range(16, 2), 1'b1, 0);
                end
                wait_for_drain();
                finish_test("multi block", e);

                // Output stalls
                e = errors;
                stall_pct = 40;
                for (int f = 0; f < 4; f++) begin
                        send_frame($urandom_range(16, 1), 1'b1, 0);
                end
                wait_for_drain();
                stall_pct = 0;
                finish_test("output back-pressure", e);

                e = errors;
                for (int f = 0; f < 4; f++) begin
                        send_frame($urandom_range(16, 1), 1'b1, 35);
                end
                wait_for_drain();
                finish_test("input gaps", e);

                e = errors;
                send_frame(max_blocks, 1'b0, 10);
                wait_for_drain();
                finish_test("full buffer", e);

                // Back to back while output is held
                e = errors;
                stall_pct = 60;
                send_frame(3, 1'b1, 0);
                send_frame(2, 1'b1, 0);
                wait_for_drain();
                stall_pct = 0;
                finish_test("ready timing", e);

                $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
                if (errors == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== aes_stream_properties.sv ====
`default_nettype none

module aes_stream_properties (
        input wire                        s00_axis_aclk,
        input wire                        rst_n,
        input wire                        s00_axis_tready,
        input wire aes_stream_pkg::word_t m00_axis_tdata,
        input wire                        m00_axis_tvalid,
        input wire                        m00_axis_tlast,
        input wire                        m00_axis_tready
);

        timeunit 1ns;
        timeprecision 100ps;

        // Stalled output must hold its word
        hold_stable: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                (m00_axis_tvalid && !m00_axis_tready) |=>
                ($stable(m00_axis_tdata) && $stable(m00_axis_tlast)))
                else $error("output changed while stalled");

        last_needs_valid: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                m00_axis_tlast |-> m00_axis_tvalid)
                else $error("tlast without tvalid");

        // Input and output phases never overlap
        no_overlap: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                !(s00_axis_tready && m00_axis_tvalid))
                else $error("input ready while output valid");

endmodule

bind aes_stream_top aes_stream_properties props_inst (
        .s00_axis_aclk   (s00_axis_aclk),
        .rst_n           (rst_n),
        .s00_axis_tready (s00_axis_tready),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tlast  (m00_axis_tlast),
        .m00_axis_tready (m00_axis_tready)
);

`default_nettype wire

// ==== aes_stream_top.sv ====
`default_nettype none

module aes_stream_top (
        input  wire                        s00_axis_aclk,
        input  wire                        rst_n,
        input  wire aes_stream_pkg::word_t s00_axis_tdata,
        input  wire                        s00_axis_tvalid,
        input  wire                        s00_axis_tlast,
        output logic                       s00_axis_tready,
        output aes_stream_pkg::word_t      m00_axis_tdata,
        output logic                       m00_axis_tvalid,
        output logic                       m00_axis_tlast,
        input  wire                        m00_axis_tready
);

        import aes_stream_pkg::*;

        ctrl_state_t state;

        logic   recv_en;
        logic   frame_done;
        logic   eng_start;
        logic   eng_done;
        logic   send_start;
        logic   send_done;
        word_t  cmd;
        count_t blk_count;

        // Input RAM side
        addr_t  pk_wr_addr;
        block_t pk_wr_data;
        logic   in_we;
        addr_t  eng_rd_addr;
        addr_t  in_addr;
        block_t in_rd_data;

        // Output RAM side
        addr_t  eng_wr_addr;
        block_t eng_wr_data;
        logic   out_we;
        addr_t  snd_rd_addr;
        addr_t  out_addr;
        block_t out_rd_data;

        // ==================================================
        // Control FSM
        // ==================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= st_idle;
                end else begin
                        case (state)
                                st_idle:    if (s00_axis_tvalid) state <= st_receive;
                                st_receive: if (frame_done) state <= st_process;
                                st_process: if (eng_done) state <= st_send;
                                st_send:    if (send_done) state <= st_idle;
                                default:    state <= st_idle;
                        endcase
                end
        end

        assign recv_en    = (state == st_receive);
        assign eng_start  = recv_en && frame_done;
        assign send_start = (state == st_process) && eng_done;

        // One address port per RAM, owner picked by state
        assign in_addr  = (state == st_process) ? eng_rd_addr : pk_wr_addr;
        assign out_addr = (state == st_send) ? snd_rd_addr : eng_wr_addr;

        // ==================================================
        // Datapath
        // ==================================================
        axis_block_packer packer_inst (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .recv_en       (recv_en),
                .tdata         (s00_axis_tdata),
                .tvalid        (s00_axis_tvalid),
                .tlast         (s00_axis_tlast),
                .tready        (s00_axis_tready),
                .cmd           (cmd),
                .blk_count     (blk_count),
                .frame_done    (frame_done),
                .wr_addr       (pk_wr_addr),
                .wr_data       (pk_wr_data),
                .wr_en         (in_we)
        );

        block_ram #(
                .data_width (block_width),
                .depth      (max_blocks)
        ) in_ram (
                .s00_axis_aclk (s00_axis_aclk),
                .addr          (in_addr),
                .wr_data       (pk_wr_data),
                .wr_en         (in_we),
                .rd_data       (in_rd_data)
        );

        block_xor_engine engine_inst (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .start         (eng_start),
                .cmd           (cmd),
                .blk_count     (blk_count),
                .rd_addr       (eng_rd_addr),
                .rd_data       (in_rd_data),
                .wr_addr       (eng_wr_addr),
                .wr_data       (eng_wr_data),
                .wr_en         (out_we),
                .done          (eng_done)
        );

        block_ram #(
                .data_width (block_width),
                .depth      (max_blocks)
        ) out_ram (
                .s00_axis_aclk (s00_axis_aclk),
                .addr          (out_addr),
                .wr_data       (eng_wr_data),
                .wr_en         (out_we),
                .rd_data       (out_rd_data)
        );

        axis_block_sender sender_inst (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .start         (send_start),
                .blk_count     (blk_count),
                .rd_addr       (snd_rd_addr),
                .rd_data       (out_rd_data),
                .tdata         (m00_axis_tdata),
                .tvalid        (m00_axis_tvalid),
                .tlast         (m00_axis_tlast),
                .tready        (m00_axis_tready),
                .done          (send_done)
        );

endmodule

`default_nettype wire

// ==== axis_block_sender.sv ====
`default_nettype none

module axis_block_sender (
        input  wire                     s00_axis_aclk,
        input  wire                     rst_n,
        input  wire                     start,
        input  wire aes_stream_pkg::count_t blk_count,
        output aes_stream_pkg::addr_t   rd_addr,
        input  wire aes_stream_pkg::block_t rd_data,
        output aes_stream_pkg::word_t   tdata,
        output logic                    tvalid,
        output logic                    tlast,
        input  wire                     tready,
        output logic                    done
);

        import aes_stream_pkg::*;

        typedef enum logic [1:0] {
                snd_idle,
                snd_fetch,
                snd_load,
                snd_send
        } snd_state_t;

        snd_state_t state;
        block_t     blk;
        word_idx_t  word_idx;
        count_t     blk_idx;
        logic       accept;
        logic       blk_end;

        // Most significant word goes out first
        assign tdata   = blk[block_width-1 -: word_width];
        assign accept  = tvalid && tready;
        assign blk_end = (word_idx == word_idx_t'(words_per_block - 1));
        assign tlast   = tvalid && blk_end && (blk_idx == blk_count - 1'b1);

        // ==================================================
        // Fetch, then send with next block prefetched
        // ==================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state    <= snd_idle;
                        rd_addr  <= '0;
                        word_idx <= '0;
                        blk_idx  <= '0;
                        tvalid   <= 1'b0;
                        done     <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                                snd_idle: begin
                                        if (start) begin
                                                rd_addr <= '0;
                                                state   <= snd_fetch;
                                        end
                                end
                                snd_fetch: begin
                                        // Output RAM is ours from here on
                                        state <= snd_load;
                                end
                                snd_load: begin
                                        tvalid  <= 1'b1;
                                        rd_addr <= rd_addr + 1'b1;
                                        state   <= snd_send;
                                end
                                snd_send: begin
                                        if (accept) begin
                                                word_idx <= word_idx + 1'b1;
                                                if (tlast) begin
                                                        tvalid   <= 1'b0;
                                                        done     <= 1'b1;
                                                        rd_addr  <= '0;
                                                        blk_idx  <= '0;
                                                        word_idx <= '0;
                                                        state    <= snd_idle;
                                                end else if (blk_end) begin
                                                        rd_addr <= rd_addr + 1'b1;
                                                        blk_idx <= blk_idx + 1'b1;
                                                end
                                        end
                                end
                                default: begin
                                        state <= snd_idle;
                                end
                        endcase
                end
        end

        // Block register shifts up one word per accepted transfer
        always_ff @(posedge s00_axis_aclk) begin
                if (state == snd_load) begin
                        blk <= rd_data;
                end else if (state == snd_send && accept) begin
                        if (blk_end) begin
                                blk <= rd_data;
                        end else begin
                                blk <= blk << word_width;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== block_xor_engine.sv ====
`default_nettype none

module block_xor_engine (
        input  wire                     s00_axis_aclk,
        input  wire                     rst_n,
        input  wire                     start,
        input  wire aes_stream_pkg::word_t  cmd,
        input  wire aes_stream_pkg::count_t blk_count,
        output aes_stream_pkg::addr_t   rd_addr,
        input  wire aes_stream_pkg::block_t rd_data,
        output aes_stream_pkg::addr_t   wr_addr,
        output aes_stream_pkg::block_t  wr_data,
        output logic                    wr_en,
        output logic                    done
);

        import aes_stream_pkg::*;

        typedef enum logic [1:0] {
                eng_idle,
                eng_read,
                eng_write
        } eng_state_t;

        eng_state_t state;
        logic       last_blk;

        assign last_blk = (count_t'(rd_addr) == blk_count - 1'b1);

        // Result goes back to the same slot in the output RAM
        assign wr_addr = rd_addr;
        assign wr_en   = (state == eng_write);
        assign wr_data = rd_data ^ {words_per_block{cmd}};

        // ==================================================
        // Two cycles per block: address, then write
        // ==================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state   <= eng_idle;
                        rd_addr <= '0;
                        done    <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                                eng_idle: begin
                                        if (start) begin
                                                rd_addr <= '0;
                                                state   <= eng_read;
                                        end
                                end
                                eng_read: begin
                                        // RAM samples rd_addr on this edge
                                        state <= eng_write;
                                end
                                eng_write: begin
                                        if (last_blk) begin
                                                done    <= 1'b1;
                                                rd_addr <= '0;
                                                state   <= eng_idle;
                                        end else begin
                                                rd_addr <= rd_addr + 1'b1;
                                                state   <= eng_read;
                                        end
                                end
                                default: begin
                                        state <= eng_idle;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== axis_block_packer.sv ====
`default_nettype none

module axis_block_packer (
        input  wire                     s00_axis_aclk,
        input  wire                     rst_n,
        input  wire                     recv_en,
        input  wire aes_stream_pkg::word_t tdata,
        input  wire                     tvalid,
        input  wire                     tlast,
        output logic                    tready,
        output aes_stream_pkg::word_t   cmd,
        output aes_stream_pkg::count_t  blk_count,
        output logic                    frame_done,
        output aes_stream_pkg::addr_t   wr_addr,
        output aes_stream_pkg::block_t  wr_data,
        output logic                    wr_en
);

        import aes_stream_pkg::*;

        logic      hold;
        logic      have_cmd;
        logic      accept;
        word_idx_t word_idx;
        count_t    blk_cnt;

        // Ready is dropped from frame end until recv_en goes low again
        assign tready = recv_en && !hold;
        assign accept = tvalid && tready;

        // ==================================================
        // Command capture and block count
        // ==================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        hold       <= 1'b0;
                        have_cmd   <= 1'b0;
                        word_idx   <= '0;
                        blk_cnt    <= '0;
                        blk_count  <= '0;
                        frame_done <= 1'b0;
                        wr_en      <= 1'b0;
                        wr_addr    <= '0;
                end else begin
                        frame_done <= 1'b0;
                        wr_en      <= 1'b0;
                        if (!recv_en) begin
                                hold <= 1'b0;
                        end
                        if (accept && !have_cmd) begin
                                have_cmd <= 1'b1;
                        end else if (accept) begin
                                word_idx <= word_idx + 1'b1;
                                if (word_idx == word_idx_t'(words_per_block - 1)) begin
                                        // Block complete, written next cycle
                                        wr_en   <= 1'b1;
                                        wr_addr <= addr_t'(blk_cnt);
                                        blk_cnt <= blk_cnt + 1'b1;
                                        if (tlast || blk_cnt == count_t'(max_blocks - 1)) begin
                                                frame_done <= 1'b1;
                                                blk_count  <= blk_cnt + 1'b1;
                                                blk_cnt    <= '0;
                                                have_cmd   <= 1'b0;
                                                hold       <= 1'b1;
                                        end
                                end
                        end
                end
        end

        // ==================================================
        // Payload path
        // ==================================================
        // First word in the block ends up as the top word
        always_ff @(posedge s00_axis_aclk) begin
                if (accept && !have_cmd) begin
                        cmd <= tdata;
                end
                if (accept && have_cmd) begin
                        wr_data <= {wr_data[block_width-word_width-1:0], tdata};
                end
        end

endmodule

`default_nettype wire

// ==== block_ram.sv ====
`default_nettype none

module block_ram #(
        parameter int data_width = 128,
        parameter int depth      = 16
) (
        input  wire                          s00_axis_aclk,
        input  wire  [$clog2(depth)-1:0]     addr,
        input  wire  [data_width-1:0]        wr_data,
        input  wire                          wr_en,
        output logic [data_width-1:0]        rd_data
);

        logic [data_width-1:0] mem [depth];

        // Single port, read returns the old entry on a write cycle
        always_ff @(posedge s00_axis_aclk) begin
                if (wr_en) begin
                        mem[addr] <= wr_data;
                end
                rd_data <= mem[addr];
        end

endmodule

`default_nettype wire

// ==== aes_stream_pkg.sv ====
`default_nettype none

package aes_stream_pkg;

        // ==================================================
        // Stream and block geometry
        // ==================================================
        localparam int word_width      = 32;
        localparam int words_per_block = 4;
        localparam int block_width     = word_width * words_per_block;

        // Buffer depth in blocks, same for both RAMs
        localparam int max_blocks = 16;
        localparam int addr_width = $clog2(max_blocks);

        // ==================================================
        // Types
        // ==================================================
        typedef logic [word_width-1:0]              word_t;
        typedef logic [block_width-1:0]             block_t;
        typedef logic [addr_width-1:0]              addr_t;
        // One extra bit so a full buffer (16) fits
        typedef logic [addr_width:0]                count_t;
        typedef logic [$clog2(words_per_block)-1:0] word_idx_t;

        // Frame sequencing in the top level
        typedef enum logic [1:0] {
                st_idle,
                st_receive,
                st_process,
                st_send
        } ctrl_state_t;

endpackage

`default_nettype wire
